/* Makefile */
VERILATOR ?= verilator
FLAGS     = --timing --assert
TOP       = fu_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
hdl/fu_pkg.sv
hdl/fu_alu.sv
hdl/fu_br.sv
hdl/fu_mult.sv
hdl/fu_main.sv
testbench/fu_tb_clk.sv
testbench/fu_tb.sv

/* hdl/fu_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module fu_alu (
	input  logic                          clk,
	input  logic                          rst_i,
	input  logic                          start_i,
	input  logic [63:0]                   opa_i,
	input  logic [63:0]                   opb_i,
	input  fu_pkg::fu_inst_t              inst_i,
	input  logic [fu_pkg::PRF_IDX_W-1:0]  dest_tag_i,
	input  logic [fu_pkg::ROB_IDX_W:0]    rob_idx_i,
	input  logic [fu_pkg::BR_MASK_W-1:0]  br_mask_i,
	input  logic                          rob_br_recovery_i,
	input  logic                          rob_br_pred_correct_i,
	input  logic [fu_pkg::BR_MASK_W-1:0]  rob_br_tag_fix_i,
	output logic [63:0]                   result_o,
	output logic [fu_pkg::PRF_IDX_W-1:0]  dest_tag_o,
	output logic [fu_pkg::ROB_IDX_W:0]    rob_idx_o,
	output logic                          done_o
);

	logic [63:0]                  opb;
	logic [63:0]                  result_nxt;
	logic [fu_pkg::BR_MASK_W-1:0] mask_r;
	logic [fu_pkg::BR_MASK_W-1:0] clr_bits;
	logic                         done_r;
	logic                         kill_in;
	logic                         kill_out;

	assign clr_bits = rob_br_pred_correct_i ? rob_br_tag_fix_i : '0;
	assign kill_in  = rob_br_recovery_i & fu_pkg::squash_hit(br_mask_i, rob_br_tag_fix_i);
	assign kill_out = rob_br_recovery_i & fu_pkg::squash_hit(mask_r, rob_br_tag_fix_i);

	assign opb = inst_i.op.lit ? {56'd0, inst_i.op.rb_lit} : opb_i;

	always_comb begin
		result_nxt = '0;
		case (inst_i.op.opcode)
			fu_pkg::OP_INTA: begin
				case (inst_i.op.func)
					fu_pkg::FN_ADDQ:   result_nxt = opa_i + opb;
					fu_pkg::FN_SUBQ:   result_nxt = opa_i - opb;
					fu_pkg::FN_CMPEQ:  result_nxt = {63'd0, opa_i == opb};
					fu_pkg::FN_CMPULT: result_nxt = {63'd0, opa_i < opb};
					default:           result_nxt = '0;
				endcase
			end
			fu_pkg::OP_INTL: begin
				case (inst_i.op.func)
					fu_pkg::FN_AND: result_nxt = opa_i & opb;
					fu_pkg::FN_BIS: result_nxt = opa_i | opb;
					fu_pkg::FN_XOR: result_nxt = opa_i ^ opb;
					default:        result_nxt = '0;
				endcase
			end
			fu_pkg::OP_INTS: begin
				// shift amount is the low 6 bits
				case (inst_i.op.func)
					fu_pkg::FN_SLL: result_nxt = opa_i << opb[5:0];
					fu_pkg::FN_SRL: result_nxt = opa_i >> opb[5:0];
					default:        result_nxt = '0;
				endcase
			end
			default: result_nxt = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			done_r <= 1'b0;
		end else begin
			done_r <= start_i & ~kill_in;
		end
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			result_o   <= result_nxt;
			dest_tag_o <= dest_tag_i;
			rob_idx_o  <= rob_idx_i;
			mask_r     <= br_mask_i & ~clr_bits;
		end
	end

	// a held result can still be hit in its done cycle
	assign done_o = done_r & ~kill_out;

	a_squashed_issue_no_done: assert property (@(posedge clk) disable iff (rst_i)
		start_i && kill_in |=> !done_o);

endmodule

`default_nettype wire

/* hdl/fu_br.sv */
`timescale 1ns/1ns
`default_nettype none

module fu_br (
	input  logic                          clk,
	input  logic                          rst_i,
	input  logic                          start_i,
	input  logic [63:0]                   npc_i,
	input  logic [63:0]                   opa_i,
	input  fu_pkg::fu_inst_t              inst_i,
	input  logic [fu_pkg::PRF_IDX_W-1:0]  dest_tag_i,
	input  logic [fu_pkg::ROB_IDX_W:0]    rob_idx_i,
	input  logic [fu_pkg::BR_MASK_W-1:0]  br_mask_i,
	input  logic                          rob_br_recovery_i,
	input  logic                          rob_br_pred_correct_i,
	input  logic [fu_pkg::BR_MASK_W-1:0]  rob_br_tag_fix_i,
	output logic                          done_o,
	output logic                          wr_en_o,
	output logic [63:0]                   result_o,
	output logic [fu_pkg::PRF_IDX_W-1:0]  dest_tag_o,
	output logic [fu_pkg::ROB_IDX_W:0]    rob_idx_o,
	output logic                          taken_o,
	output logic [63:0]                   target_o
);

	logic                         taken_nxt;
	logic                         link_nxt;
	logic [63:0]                  disp_ext;
	logic [fu_pkg::BR_MASK_W-1:0] mask_r;
	logic [fu_pkg::BR_MASK_W-1:0] clr_bits;
	logic                         done_r;
	logic                         wr_en_r;
	logic                         kill_in;
	logic                         kill_out;

	assign clr_bits = rob_br_pred_correct_i ? rob_br_tag_fix_i : '0;
	assign kill_in  = rob_br_recovery_i & fu_pkg::squash_hit(br_mask_i, rob_br_tag_fix_i);
	assign kill_out = rob_br_recovery_i & fu_pkg::squash_hit(mask_r, rob_br_tag_fix_i);

	// word displacement
	assign disp_ext = {{41{inst_i.br.disp[20]}}, inst_i.br.disp, 2'b00};

	always_comb begin
		link_nxt  = 1'b0;
		taken_nxt = 1'b0;
		case (inst_i.br.opcode)
			fu_pkg::OP_BR, fu_pkg::OP_BSR: begin
				link_nxt  = 1'b1;
				taken_nxt = 1'b1;
			end
			fu_pkg::OP_BEQ: taken_nxt = (opa_i == 64'd0);
			fu_pkg::OP_BNE: taken_nxt = (opa_i != 64'd0);
			// signed tests only need the sign bit
			fu_pkg::OP_BLT: taken_nxt = opa_i[63];
			fu_pkg::OP_BGE: taken_nxt = ~opa_i[63];
			default:        taken_nxt = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			done_r  <= 1'b0;
			wr_en_r <= 1'b0;
		end else begin
			done_r  <= start_i & ~kill_in;
			wr_en_r <= start_i & ~kill_in & link_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			result_o   <= npc_i;
			target_o   <= npc_i + disp_ext;
			taken_o    <= taken_nxt;
			dest_tag_o <= dest_tag_i;
			rob_idx_o  <= rob_idx_i;
			mask_r     <= br_mask_i & ~clr_bits;
		end
	end

	assign done_o  = done_r & ~kill_out;
	assign wr_en_o = wr_en_r & ~kill_out;

	a_wr_en_needs_done: assert property (@(posedge clk) disable iff (rst_i)
		wr_en_o |-> done_o);

endmodule

`default_nettype wire

/* hdl/fu_main.sv */
`timescale 1ns/1ns
`default_nettype none

module fu_main (
	input  logic                          clk,
	input  logic                          rst_i,
	input  logic                          iss_vld_i,
	input  logic [fu_pkg::FU_SEL_W-1:0]   sel_i,
	input  logic [31:0]                   inst_i,
	input  logic [63:0]                   npc_i,
	input  logic [63:0]                   ra_value_i,
	input  logic [63:0]                   rb_value_i,
	input  logic [fu_pkg::PRF_IDX_W-1:0]  dest_tag_i,
	input  logic [fu_pkg::ROB_IDX_W:0]    rob_idx_i,
	input  logic [fu_pkg::BR_MASK_W-1:0]  br_mask_i,
	input  logic                          rob_br_recovery_i,
	input  logic                          rob_br_pred_correct_i,
	input  logic [fu_pkg::BR_MASK_W-1:0]  rob_br_tag_fix_i,
	output logic                          iss_rdy_o,
	output logic                          cdb_vld_o,
	output logic [fu_pkg::PRF_IDX_W-1:0]  cdb_tag_o,
	output logic [63:0]                   cdb_value_o,
	output logic                          fu2rob_done_o,
	output logic [fu_pkg::ROB_IDX_W:0]    fu2rob_idx_o,
	output logic                          br_done_o,
	output logic                          br_taken_o,
	output logic [63:0]                   br_target_o,
	output logic                          br_mispredict_o
);

	logic                         accept;
	logic                         alu_start;
	logic                         br_start;
	logic                         mult_start;
	logic                         mult_stall;
	logic                         mult_busy;

	logic [63:0]                  alu_result;
	logic [fu_pkg::PRF_IDX_W-1:0] alu_dest_tag;
	logic [fu_pkg::ROB_IDX_W:0]   alu_rob_idx;
	logic                         alu_done;

	logic                         br_done;
	logic                         br_wr_en;
	logic [63:0]                  br_link;
	logic [fu_pkg::PRF_IDX_W-1:0] br_dest_tag;
	logic [fu_pkg::ROB_IDX_W:0]   br_rob_idx;
	logic                         br_taken;
	logic [63:0]                  br_target;

	logic [63:0]                  mult_product;
	logic [fu_pkg::PRF_IDX_W-1:0] mult_dest_tag;
	logic [fu_pkg::ROB_IDX_W:0]   mult_rob_idx;
	logic                         mult_done;

	logic                         wb_vld;
	logic [fu_pkg::PRF_IDX_W-1:0] wb_tag;
	logic [63:0]                  wb_value;
	logic [fu_pkg::ROB_IDX_W:0]   wb_idx;

	// only a mult issue can be held off
	assign iss_rdy_o = ~((sel_i == fu_pkg::FU_SEL_MULT) & mult_busy);
	assign accept    = iss_vld_i & iss_rdy_o;

	assign alu_start  = accept & (sel_i == fu_pkg::FU_SEL_ALU);
	assign br_start   = accept & ((sel_i == fu_pkg::FU_SEL_COND_BRANCH) |
		(sel_i == fu_pkg::FU_SEL_UNCOND_BRANCH));
	assign mult_start = accept & (sel_i == fu_pkg::FU_SEL_MULT);

	// mult loses the cdb slot to alu/branch, and to a recovery blanking
	assign mult_stall = alu_done | br_done | rob_br_recovery_i;

	fu_alu u_alu (
		.clk                   (clk),
		.rst_i                 (rst_i),
		.start_i               (alu_start),
		.opa_i                 (ra_value_i),
		.opb_i                 (rb_value_i),
		.inst_i                (inst_i),
		.dest_tag_i            (dest_tag_i),
		.rob_idx_i             (rob_idx_i),
		.br_mask_i             (br_mask_i),
		.rob_br_recovery_i     (rob_br_recovery_i),
		.rob_br_pred_correct_i (rob_br_pred_correct_i),
		.rob_br_tag_fix_i      (rob_br_tag_fix_i),
		.result_o              (alu_result),
		.dest_tag_o            (alu_dest_tag),
		.rob_idx_o             (alu_rob_idx),
		.done_o                (alu_done)
	);

	fu_br u_br (
		.clk                   (clk),
		.rst_i                 (rst_i),
		.start_i               (br_start),
		.npc_i                 (npc_i),
		.opa_i                 (ra_value_i),
		.inst_i                (inst_i),
		.dest_tag_i            (dest_tag_i),
		.rob_idx_i             (rob_idx_i),
		.br_mask_i             (br_mask_i),
		.rob_br_recovery_i     (rob_br_recovery_i),
		.rob_br_pred_correct_i (rob_br_pred_correct_i),
		.rob_br_tag_fix_i      (rob_br_tag_fix_i),
		.done_o                (br_done),
		.wr_en_o               (br_wr_en),
		.result_o              (br_link),
		.dest_tag_o            (br_dest_tag),
		.rob_idx_o             (br_rob_idx),
		.taken_o               (br_taken),
		.target_o              (br_target)
	);

	fu_mult u_mult (
		.clk                   (clk),
		.rst_i                 (rst_i),
		.start_i               (mult_start),
		.opa_i                 (ra_value_i),
		.opb_i                 (rb_value_i),
		.inst_i                (inst_i),
		.dest_tag_i            (dest_tag_i),
		.rob_idx_i             (rob_idx_i),
		.br_mask_i             (br_mask_i),
		.rob_br_recovery_i     (rob_br_recovery_i),
		.rob_br_pred_correct_i (rob_br_pred_correct_i),
		.rob_br_tag_fix_i      (rob_br_tag_fix_i),
		.stall_i               (mult_stall),
		.product_o             (mult_product),
		.dest_tag_o            (mult_dest_tag),
		.rob_idx_o             (mult_rob_idx),
		.done_o                (mult_done),
		.busy_o                (mult_busy)
	);

	// branch over alu over mult
	always_comb begin
		if (br_done) begin
			wb_vld   = br_wr_en;
			wb_tag   = br_dest_tag;
			wb_value = br_link;
			wb_idx   = br_rob_idx;
		end else if (alu_done) begin
			wb_vld   = 1'b1;
			wb_tag   = alu_dest_tag;
			wb_value = alu_result;
			wb_idx   = alu_rob_idx;
		end else if (mult_done) begin
			wb_vld   = 1'b1;
			wb_tag   = mult_dest_tag;
			wb_value = mult_product;
			wb_idx   = mult_rob_idx;
		end else begin
			wb_vld   = 1'b0;
			wb_tag   = fu_pkg::ZERO_REG;
			wb_value = '0;
			wb_idx   = '0;
		end
	end

	assign cdb_vld_o     = wb_vld & ~rob_br_recovery_i;
	assign cdb_tag_o     = wb_tag;
	assign cdb_value_o   = wb_value;
	assign fu2rob_done_o = (br_done | alu_done | mult_done) & ~rob_br_recovery_i;
	assign fu2rob_idx_o  = wb_idx;

	// predicted not taken, so any taken branch is a mispredict
	assign br_done_o       = br_done & ~rob_br_recovery_i;
	assign br_taken_o      = br_taken;
	assign br_target_o     = br_target;
	assign br_mispredict_o = br_done_o & br_taken;

	a_one_start: assert property (@(posedge clk) disable iff (rst_i)
		$onehot0({alu_start, br_start, mult_start}));

endmodule

`default_nettype wire

/* hdl/fu_mult.sv */
`timescale 1ns/1ns
`default_nettype none

module fu_mult (
	input  logic                          clk,
	input  logic                          rst_i,
	input  logic                          start_i,
	input  logic [63:0]                   opa_i,
	input  logic [63:0]                   opb_i,
	input  fu_pkg::fu_inst_t              inst_i,
	input  logic [fu_pkg::PRF_IDX_W-1:0]  dest_tag_i,
	input  logic [fu_pkg::ROB_IDX_W:0]    rob_idx_i,
	input  logic [fu_pkg::BR_MASK_W-1:0]  br_mask_i,
	input  logic                          rob_br_recovery_i,
	input  logic                          rob_br_pred_correct_i,
	input  logic [fu_pkg::BR_MASK_W-1:0]  rob_br_tag_fix_i,
	input  logic                          stall_i,
	output logic [63:0]                   product_o,
	output logic [fu_pkg::PRF_IDX_W-1:0]  dest_tag_o,
	output logic [fu_pkg::ROB_IDX_W:0]    rob_idx_o,
	output logic                          done_o,
	output logic                          busy_o
);

	logic [fu_pkg::MULT_STAGES-1:0] vld_q;
	logic [fu_pkg::MULT_STAGES-1:0] kill;
	logic [fu_pkg::BR_MASK_W-1:0]   mask_q [fu_pkg::MULT_STAGES];
	logic [fu_pkg::PRF_IDX_W-1:0]   tag_q  [fu_pkg::MULT_STAGES];
	logic [fu_pkg::ROB_IDX_W:0]     idx_q  [fu_pkg::MULT_STAGES];
	logic [63:0]                    acc_q  [fu_pkg::MULT_STAGES];
	logic [63:0]                    a_q    [fu_pkg::MULT_STAGES-1];
	logic [63:0]                    b_q    [fu_pkg::MULT_STAGES-1];
	logic [63:0]                    opb;
	logic [fu_pkg::BR_MASK_W-1:0]   clr_bits;
	logic                           kill_in;

	assign clr_bits = rob_br_pred_correct_i ? rob_br_tag_fix_i : '0;
	assign kill_in  = rob_br_recovery_i & fu_pkg::squash_hit(br_mask_i, rob_br_tag_fix_i);
	assign opb      = inst_i.op.lit ? {56'd0, inst_i.op.rb_lit} : opb_i;

	always_comb begin
		for (int s = 0; s < fu_pkg::MULT_STAGES; s++) begin
			kill[s] = rob_br_recovery_i & fu_pkg::squash_hit(mask_q[s], rob_br_tag_fix_i);
		end
	end

	// whole pipe freezes while the finished product waits for the cdb
	assign busy_o = stall_i & vld_q[fu_pkg::MULT_STAGES-1];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			vld_q <= '0;
		end else if (busy_o) begin
			vld_q <= vld_q & ~kill;
		end else begin
			vld_q <= {vld_q[fu_pkg::MULT_STAGES-2:0] & ~kill[fu_pkg::MULT_STAGES-2:0],
				start_i & ~kill_in};
		end
	end

	always_ff @(posedge clk) begin
		if (busy_o) begin
			for (int s = 0; s < fu_pkg::MULT_STAGES; s++) begin
				mask_q[s] <= mask_q[s] & ~clr_bits;
			end
		end else begin
			// stage 0 takes the lowest 16-bit slice of b
			mask_q[0] <= br_mask_i & ~clr_bits;
			tag_q[0]  <= dest_tag_i;
			idx_q[0]  <= rob_idx_i;
			acc_q[0]  <= opa_i * {48'd0, opb[15:0]};
			a_q[0]    <= opa_i;
			b_q[0]    <= opb;
			for (int s = 1; s < fu_pkg::MULT_STAGES; s++) begin
				mask_q[s] <= mask_q[s-1] & ~clr_bits;
				tag_q[s]  <= tag_q[s-1];
				idx_q[s]  <= idx_q[s-1];
				acc_q[s]  <= acc_q[s-1] +
					((a_q[s-1] * {48'd0, b_q[s-1][16*s +: 16]}) << (16 * s));
			end
			for (int s = 1; s < fu_pkg::MULT_STAGES - 1; s++) begin
				a_q[s] <= a_q[s-1];
				b_q[s] <= b_q[s-1];
			end
		end
	end

	assign product_o  = acc_q[fu_pkg::MULT_STAGES-1];
	assign dest_tag_o = tag_q[fu_pkg::MULT_STAGES-1];
	assign rob_idx_o  = idx_q[fu_pkg::MULT_STAGES-1];
	assign done_o     = vld_q[fu_pkg::MULT_STAGES-1] & ~kill[fu_pkg::MULT_STAGES-1];

	a_held_output_stable: assert property (@(posedge clk) disable iff (rst_i)
		busy_o |=> $stable(product_o) && $stable(dest_tag_o) && $stable(rob_idx_o));

endmodule

`default_nettype wire

/* hdl/fu_pkg.sv */
`default_nettype none

package fu_pkg;

	localparam int PRF_IDX_W   = 6;
	localparam int ROB_IDX_W   = 5;
	localparam int BR_MASK_W   = 4;
	localparam int FU_SEL_W    = 3;
	localparam int MULT_STAGES = 4;

	// tag 31 means no register write
	localparam logic [PRF_IDX_W-1:0] ZERO_REG = 6'd31;

	localparam logic [FU_SEL_W-1:0] FU_SEL_NONE         = 3'd0;
	localparam logic [FU_SEL_W-1:0] FU_SEL_ALU          = 3'd1;
	localparam logic [FU_SEL_W-1:0] FU_SEL_COND_BRANCH  = 3'd2;
	localparam logic [FU_SEL_W-1:0] FU_SEL_UNCOND_BRANCH = 3'd3;
	localparam logic [FU_SEL_W-1:0] FU_SEL_MULT         = 3'd4;

	// operate groups
	localparam logic [5:0] OP_INTA = 6'h10;
	localparam logic [5:0] OP_INTL = 6'h11;
	localparam logic [5:0] OP_INTS = 6'h12;
	localparam logic [5:0] OP_INTM = 6'h13;

	localparam logic [6:0] FN_ADDQ   = 7'h20;
	localparam logic [6:0] FN_SUBQ   = 7'h29;
	localparam logic [6:0] FN_CMPEQ  = 7'h2d;
	localparam logic [6:0] FN_CMPULT = 7'h1d;
	localparam logic [6:0] FN_AND    = 7'h00;
	localparam logic [6:0] FN_BIS    = 7'h20;
	localparam logic [6:0] FN_XOR    = 7'h40;
	localparam logic [6:0] FN_SLL    = 7'h39;
	localparam logic [6:0] FN_SRL    = 7'h34;
	localparam logic [6:0] FN_MULQ   = 7'h20;

	// branch opcodes
	localparam logic [5:0] OP_BR  = 6'h30;
	localparam logic [5:0] OP_BSR = 6'h34;
	localparam logic [5:0] OP_BEQ = 6'h39;
	localparam logic [5:0] OP_BNE = 6'h3d;
	localparam logic [5:0] OP_BLT = 6'h3a;
	localparam logic [5:0] OP_BGE = 6'h3e;

	// rb sits in the top 5 bits of rb_lit when lit is clear
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] ra;
		logic [7:0] rb_lit;
		logic       lit;
		logic [6:0] func;
		logic [4:0] rc;
	} fu_op_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  ra;
		logic [20:0] disp;
	} fu_br_fmt_t;

	typedef union packed {
		fu_op_fmt_t op;
		fu_br_fmt_t br;
	} fu_inst_t;

	function automatic logic squash_hit(
		input logic [BR_MASK_W-1:0] mask,
		input logic [BR_MASK_W-1:0] fix
	);
		return |(mask & fix);
	endfunction

endpackage

`default_nettype wire

/* testbench/fu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module fu_tb;

	localparam int N_OPS   = 400;
	localparam int TIMEOUT = 20 * N_OPS + 200;
	localparam int DRAIN   = 50;
	localparam int N_IDX   = 2 ** (fu_pkg::ROB_IDX_W + 1);
	localparam int K_ALU   = 0;
	localparam int K_BR    = 1;
	localparam int K_MULT  = 2;

	logic                         clk;
	logic                         rst_i;
	logic                         iss_vld_i;
	logic [fu_pkg::FU_SEL_W-1:0]  sel_i;
	logic [31:0]                  inst_i;
	logic [63:0]                  npc_i;
	logic [63:0]                  ra_value_i;
	logic [63:0]                  rb_value_i;
	logic [fu_pkg::PRF_IDX_W-1:0] dest_tag_i;
	logic [fu_pkg::ROB_IDX_W:0]   rob_idx_i;
	logic [fu_pkg::BR_MASK_W-1:0] br_mask_i;
	logic                         rob_br_recovery_i;
	logic                         rob_br_pred_correct_i;
	logic [fu_pkg::BR_MASK_W-1:0] rob_br_tag_fix_i;
	logic                         iss_rdy_o;
	logic                         cdb_vld_o;
	logic [fu_pkg::PRF_IDX_W-1:0] cdb_tag_o;
	logic [63:0]                  cdb_value_o;
	logic                         fu2rob_done_o;
	logic [fu_pkg::ROB_IDX_W:0]   fu2rob_idx_o;
	logic                         br_done_o;
	logic                         br_taken_o;
	logic [63:0]                  br_target_o;
	logic                         br_mispredict_o;

	// reference model, one entry per rob index
	logic                         ent_vld    [N_IDX];
	int                           ent_kind   [N_IDX];
	logic [fu_pkg::PRF_IDX_W-1:0] ent_tag    [N_IDX];
	logic [63:0]                  ent_val    [N_IDX];
	logic                         ent_wr     [N_IDX];
	logic [fu_pkg::BR_MASK_W-1:0] ent_mask   [N_IDX];
	logic                         ent_taken  [N_IDX];
	logic [63:0]                  ent_target [N_IDX];
	int                           ent_cycle  [N_IDX];

	// expected outcome of the op now on the issue port
	int                           nxt_kind;
	logic [63:0]                  nxt_val;
	logic                         nxt_wr;
	logic                         nxt_taken;
	logic [63:0]                  nxt_target;

	logic [31:0]                  rng;
	logic [fu_pkg::ROB_IDX_W:0]   next_idx;
	int                           cyc;
	int                           drain;
	int                           live;
	int                           accepted;
	int                           squashed;
	int                           held;
	int                           prev_fast;
	int                           mismatches;
	int                           failures;
	int                           watch = 0;

	fu_tb_clk clk_gen (
		.clk_o (clk)
	);

	fu_main UUT (
		.clk                   (clk),
		.rst_i                 (rst_i),
		.iss_vld_i             (iss_vld_i),
		.sel_i                 (sel_i),
		.inst_i                (inst_i),
		.npc_i                 (npc_i),
		.ra_value_i            (ra_value_i),
		.rb_value_i            (rb_value_i),
		.dest_tag_i            (dest_tag_i),
		.rob_idx_i             (rob_idx_i),
		.br_mask_i             (br_mask_i),
		.rob_br_recovery_i     (rob_br_recovery_i),
		.rob_br_pred_correct_i (rob_br_pred_correct_i),
		.rob_br_tag_fix_i      (rob_br_tag_fix_i),
		.iss_rdy_o             (iss_rdy_o),
		.cdb_vld_o             (cdb_vld_o),
		.cdb_tag_o             (cdb_tag_o),
		.cdb_value_o           (cdb_value_o),
		.fu2rob_done_o         (fu2rob_done_o),
		.fu2rob_idx_o          (fu2rob_idx_o),
		.br_done_o             (br_done_o),
		.br_taken_o            (br_taken_o),
		.br_target_o           (br_target_o),
		.br_mispredict_o       (br_mispredict_o)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic rand64(output logic [63:0] v);
		rng = xorshift32(rng);
		v[63:32] = rng;
		rng = xorshift32(rng);
		v[31:0] = rng;
	endtask

	function automatic logic [12:0] alu_op(input int k);
		case (k)
			0:       return {fu_pkg::OP_INTA, fu_pkg::FN_ADDQ};
			1:       return {fu_pkg::OP_INTA, fu_pkg::FN_SUBQ};
			2:       return {fu_pkg::OP_INTA, fu_pkg::FN_CMPEQ};
			3:       return {fu_pkg::OP_INTA, fu_pkg::FN_CMPULT};
			4:       return {fu_pkg::OP_INTL, fu_pkg::FN_AND};
			5:       return {fu_pkg::OP_INTL, fu_pkg::FN_BIS};
			6:       return {fu_pkg::OP_INTL, fu_pkg::FN_XOR};
			7:       return {fu_pkg::OP_INTS, fu_pkg::FN_SLL};
			default: return {fu_pkg::OP_INTS, fu_pkg::FN_SRL};
		endcase
	endfunction

	function automatic logic [5:0] br_op(input logic [2:0] k);
		case (k)
			3'd0:    return fu_pkg::OP_BEQ;
			3'd1:    return fu_pkg::OP_BNE;
			3'd2:    return fu_pkg::OP_BLT;
			3'd3:    return fu_pkg::OP_BGE;
			3'd4:    return fu_pkg::OP_BR;
			default: return fu_pkg::OP_BSR;
		endcase
	endfunction

	function automatic logic [63:0] alu_model(
		input logic [5:0]  opcode,
		input logic [6:0]  func,
		input logic [63:0] a,
		input logic [63:0] b
	);
		case ({opcode, func})
			{fu_pkg::OP_INTA, fu_pkg::FN_ADDQ}:   return a + b;
			{fu_pkg::OP_INTA, fu_pkg::FN_SUBQ}:   return a - b;
			{fu_pkg::OP_INTA, fu_pkg::FN_CMPEQ}:  return (a == b) ? 64'd1 : 64'd0;
			{fu_pkg::OP_INTA, fu_pkg::FN_CMPULT}: return (a < b) ? 64'd1 : 64'd0;
			{fu_pkg::OP_INTL, fu_pkg::FN_AND}:    return a & b;
			{fu_pkg::OP_INTL, fu_pkg::FN_BIS}:    return a | b;
			{fu_pkg::OP_INTL, fu_pkg::FN_XOR}:    return a ^ b;
			{fu_pkg::OP_INTS, fu_pkg::FN_SLL}:    return a << b[5:0];
			{fu_pkg::OP_INTS, fu_pkg::FN_SRL}:    return a >> b[5:0];
			default:                              return 64'd0;
		endcase
	endfunction

	function automatic logic br_taken_model(input logic [5:0] opcode, input logic [63:0] a);
		case (opcode)
			fu_pkg::OP_BR, fu_pkg::OP_BSR: return 1'b1;
			fu_pkg::OP_BEQ:                return a == 64'd0;
			fu_pkg::OP_BNE:                return a != 64'd0;
			fu_pkg::OP_BLT:                return $signed(a) < 64'sd0;
			fu_pkg::OP_BGE:                return $signed(a) >= 64'sd0;
			default:                       return 1'b0;
		endcase
	endfunction

	function automatic string kind_name(input int kind);
		case (kind)
			K_ALU:   return "alu";
			K_BR:    return "branch";
			default: return "mult";
		endcase
	endfunction

	task automatic report_mismatch(input string test, input logic [63:0] exp,
		input logic [63:0] act);
		mismatches++;
		$display("MISMATCH %s: expected %h, actual %h (cycle %0d)", test, exp, act, cyc);
	endtask

	task automatic report_failure(input string msg);
		failures++;
		$display("ERROR at cycle %0d: %s", cyc, msg);
	endtask

	task automatic drive_idle();
		iss_vld_i             = 1'b0;
		sel_i                 = fu_pkg::FU_SEL_NONE;
		inst_i                = '0;
		npc_i                 = '0;
		ra_value_i            = '0;
		rb_value_i            = '0;
		dest_tag_i            = '0;
		rob_idx_i             = '0;
		br_mask_i             = '0;
		rob_br_recovery_i     = 1'b0;
		rob_br_pred_correct_i = 1'b0;
		rob_br_tag_fix_i      = '0;
	endtask

	task automatic drive_pulses();
		logic [fu_pkg::BR_MASK_W-1:0] fix;
		rng = xorshift32(rng);
		fix = 4'b0001 << rng[1:0];
		rob_br_tag_fix_i      = fix;
		rob_br_recovery_i     = 1'b0;
		rob_br_pred_correct_i = 1'b0;
		if (rng[7:4] == 4'd0) begin
			// a surviving alu/branch result due now would be blanked and lost
			if (prev_fast < 0 || !ent_vld[prev_fast] || (ent_mask[prev_fast] & fix) != '0)
				rob_br_recovery_i = 1'b1;
		end else if (rng[7:4] == 4'd1) begin
			rob_br_pred_correct_i = 1'b1;
		end
	endtask

	task automatic drive_issue();
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] bop;
		logic [63:0] npc;
		logic [31:0] r;
		logic [31:0] s;
		logic [5:0]  opcode;
		logic [6:0]  func;
		rand64(a);
		rand64(b);
		rand64(npc);
		rng = xorshift32(rng);
		r = rng;
		rng = xorshift32(rng);
		s = rng;
		// zero and equal operands now and then
		if (r[3:0] == 4'd0)
			a = 64'd0;
		if (r[7:4] == 4'd0)
			b = a;
		bop = r[16] ? {56'd0, r[15:8]} : b;
		npc = {npc[63:2], 2'b00};
		while (ent_vld[next_idx])
			next_idx = next_idx + 6'd1;
		iss_vld_i  = 1'b1;
		ra_value_i = a;
		rb_value_i = b;
		npc_i      = npc;
		br_mask_i  = r[17] ? r[21:18] : 4'd0;
		dest_tag_i = (r[26:22] == 5'd31) ? 6'd1 : {1'b0, r[26:22]};
		rob_idx_i  = next_idx;
		nxt_wr     = 1'b1;
		nxt_taken  = 1'b0;
		nxt_target = 64'd0;
		if (r[31:28] < 4'd6) begin
			{opcode, func} = alu_op(int'(s % 32'd9));
			sel_i    = fu_pkg::FU_SEL_ALU;
			inst_i   = {opcode, s[4:0], r[15:8], r[16], func, s[9:5]};
			nxt_kind = K_ALU;
			nxt_val  = alu_model(opcode, func, a, bop);
		end else if (r[31:28] < 4'd10) begin
			sel_i    = fu_pkg::FU_SEL_MULT;
			inst_i   = {fu_pkg::OP_INTM, s[4:0], r[15:8], r[16], fu_pkg::FN_MULQ, s[9:5]};
			nxt_kind = K_MULT;
			nxt_val  = a * bop;
		end else if (r[31:28] < 4'd13) begin
			opcode     = (r[31:28] == 4'd12) ? br_op({2'b10, s[0]}) : br_op({1'b0, s[1:0]});
			sel_i      = (r[31:28] == 4'd12) ? fu_pkg::FU_SEL_UNCOND_BRANCH :
				fu_pkg::FU_SEL_COND_BRANCH;
			inst_i     = {opcode, s[4:0], s[30:10]};
			nxt_kind   = K_BR;
			nxt_val    = npc;
			nxt_wr     = (opcode == fu_pkg::OP_BR) || (opcode == fu_pkg::OP_BSR);
			nxt_taken  = br_taken_model(opcode, a);
			nxt_target = npc + (64'($signed(s[30:10])) << 2);
		end else begin
			iss_vld_i = 1'b0;
			sel_i     = fu_pkg::FU_SEL_NONE;
		end
	endtask

	task automatic check_outputs();
		int    idx;
		string tname;
		assert (iss_rdy_o || sel_i == fu_pkg::FU_SEL_MULT) else
			report_failure("iss_rdy_o low for an issue that is not a multiply");
		if (iss_vld_i && !iss_rdy_o)
			held++;
		if (!fu2rob_done_o) begin
			assert (!cdb_vld_o && !br_done_o) else
				report_failure("cdb or branch valid without fu2rob_done_o");
			return;
		end
		idx = int'(fu2rob_idx_o);
		assert (ent_vld[idx]) else
			report_failure($sformatf("write-back for rob index %0d with no live op", idx));
		if (!ent_vld[idx])
			return;
		tname = $sformatf("%s rob %0d", kind_name(ent_kind[idx]), idx);
		assert (cdb_vld_o == ent_wr[idx]) else
			report_mismatch({tname, " cdb_vld"}, 64'(ent_wr[idx]), 64'(cdb_vld_o));
		if (ent_wr[idx]) begin
			assert (cdb_tag_o == ent_tag[idx]) else
				report_mismatch({tname, " cdb_tag"}, 64'(ent_tag[idx]), 64'(cdb_tag_o));
			assert (cdb_value_o == ent_val[idx]) else
				report_mismatch({tname, " cdb_value"}, ent_val[idx], cdb_value_o);
		end
		assert (br_done_o == (ent_kind[idx] == K_BR)) else
			report_mismatch({tname, " br_done"}, 64'(ent_kind[idx] == K_BR), 64'(br_done_o));
		if (ent_kind[idx] == K_BR) begin
			assert (br_taken_o == ent_taken[idx]) else
				report_mismatch({tname, " taken"}, 64'(ent_taken[idx]), 64'(br_taken_o));
			assert (br_target_o == ent_target[idx]) else
				report_mismatch({tname, " target"}, ent_target[idx], br_target_o);
			assert (br_mispredict_o == ent_taken[idx]) else
				report_mismatch({tname, " mispredict"}, 64'(ent_taken[idx]),
					64'(br_mispredict_o));
		end
		if (ent_kind[idx] == K_MULT) begin
			assert (cyc >= ent_cycle[idx] + fu_pkg::MULT_STAGES) else
				report_failure($sformatf("multiply for rob %0d finished too early", idx));
		end else begin
			assert (cyc == ent_cycle[idx] + 1) else
				report_mismatch({tname, " latency"}, 64'(ent_cycle[idx] + 1), 64'(cyc));
		end
		ent_vld[idx] = 1'b0;
		live--;
	endtask

	task automatic apply_pulses();
		for (int i = 0; i < N_IDX; i++) begin
			if (ent_vld[i] && rob_br_recovery_i && (ent_mask[i] & rob_br_tag_fix_i) != '0) begin
				ent_vld[i] = 1'b0;
				live--;
				squashed++;
			end
			if (rob_br_pred_correct_i)
				ent_mask[i] = ent_mask[i] & ~rob_br_tag_fix_i;
		end
	endtask

	task automatic record_issue();
		int                           idx;
		logic [fu_pkg::BR_MASK_W-1:0] mask;
		prev_fast = -1;
		if (!(iss_vld_i && iss_rdy_o))
			return;
		idx      = int'(rob_idx_i);
		mask     = br_mask_i;
		accepted++;
		next_idx = next_idx + 6'd1;
		// issued into its own recovery
		if (rob_br_recovery_i && (mask & rob_br_tag_fix_i) != '0) begin
			squashed++;
			return;
		end
		if (rob_br_pred_correct_i)
			mask = mask & ~rob_br_tag_fix_i;
		ent_vld[idx]    = 1'b1;
		ent_kind[idx]   = nxt_kind;
		ent_tag[idx]    = dest_tag_i;
		ent_val[idx]    = nxt_val;
		ent_wr[idx]     = nxt_wr;
		ent_mask[idx]   = mask;
		ent_taken[idx]  = nxt_taken;
		ent_target[idx] = nxt_target;
		ent_cycle[idx]  = cyc;
		live++;
		if (nxt_kind != K_MULT)
			prev_fast = idx;
	endtask

	always @(posedge clk) begin
		watch <= watch + 1;
		if (watch >= TIMEOUT) begin
			$display("timeout after %0d cycles with %0d ops still in flight", watch, live);
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin
		rng        = 32'h0df2_3a13;
		next_idx   = '0;
		cyc        = 0;
		drain      = 0;
		live       = 0;
		accepted   = 0;
		squashed   = 0;
		held       = 0;
		prev_fast  = -1;
		mismatches = 0;
		failures   = 0;
		nxt_kind   = K_ALU;
		nxt_val    = '0;
		nxt_wr     = 1'b0;
		nxt_taken  = 1'b0;
		nxt_target = '0;
		for (int i = 0; i < N_IDX; i++)
			ent_vld[i] = 1'b0;
		rst_i = 1'b1;
		drive_idle();
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;
		#1;
		assert (!cdb_vld_o && !fu2rob_done_o && !br_done_o && !br_mispredict_o && iss_rdy_o)
			else report_failure("outputs not idle after reset");

		while (accepted < N_OPS) begin
			@(negedge clk);
			cyc++;
			drive_pulses();
			drive_issue();
			#1;
			check_outputs();
			apply_pulses();
			record_issue();
		end

		// let the multiplier pipe empty out
		while (live > 0 && drain < DRAIN) begin
			@(negedge clk);
			cyc++;
			drain++;
			drive_idle();
			#1;
			check_outputs();
			record_issue();
		end
		for (int i = 0; i < N_IDX; i++) begin
			assert (!ent_vld[i]) else
				report_failure($sformatf("op at rob index %0d never completed", i));
		end

		$display("%0d ops accepted, %0d squashed, %0d multiply issues held off",
			accepted, squashed, held);
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches + failures == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/fu_tb_clk.sv */
`timescale 1ns/1ns
`default_nettype none

module fu_tb_clk (
	output logic clk_o
);

	// half of the 8 ns period
	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o;
	end

endmodule

`default_nettype wire
